// ==== src/pulse_pkg.sv ====
`default_nettype none

package pulse_pkg;

  // ====================
  // pulse input side
  // ====================

  // one pin per channel
  localparam int NUM_CHANNELS = 4;

  // metastability flops ahead of the edge detect
  localparam int SYNC_STAGES = 2;

  // per-channel bit vector: pins, strobes, levels, flags
  typedef logic [NUM_CHANNELS-1:0] pulse_vec_t;

  // host channel select
  typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_sel_t;

endpackage

`default_nettype wire

// ==== src/buffer_pkg.sv ====
`default_nettype none

package buffer_pkg;

  // ====================
  // field widths
  // ====================

  localparam int COUNT_W = 32;
  localparam int ADDR_W  = 15;
  localparam int BANK_W  = 16;

  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [BANK_W-1:0]  bank_t;

  // ====================
  // buffer marks
  // ====================

  // last address of the lower half
  localparam addr_t HALF_MARK = addr_t'(16383);
  // last address of the upper half, wraps to zero after this
  localparam addr_t FULL_MARK = addr_t'(32767);

  // per-channel status word, 64 bits, count in the top bits
  typedef struct packed {
    count_t count;
    addr_t  addr;
    bank_t  bank;
    logic   half_flag;
  } chan_status_t;

endpackage

`default_nettype wire

// ==== src/pulse_sync_bank.sv ====
`default_nettype none
`timescale 1ns/1ps

module pulse_sync_bank (
  input  wire                  GPIO,
  input  wire                  hps_fpga_reset_n,
  input  wire pulse_pkg::pulse_vec_t pulse_in,
  output pulse_pkg::pulse_vec_t      rise,
  output pulse_pkg::pulse_vec_t      pin_level
);

  // sync chain, stage 0 takes the raw pins
  pulse_pkg::pulse_vec_t sync_q [pulse_pkg::SYNC_STAGES];
  // previous synchronized level
  pulse_pkg::pulse_vec_t hist_q;
  // registered one-cycle edge strobes
  pulse_pkg::pulse_vec_t rise_q;

  // ====================
  // synchronizer
  // ====================

  always_ff @(posedge GPIO or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      for (int s = 0; s < pulse_pkg::SYNC_STAGES; s++)
      begin
        sync_q[s] <= '0;
      end
    end
    else
    begin
      sync_q[0] <= pulse_in;
      for (int s = 1; s < pulse_pkg::SYNC_STAGES; s++)
      begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // ====================
  // edge detect
  // ====================

  always_ff @(posedge GPIO or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      hist_q <= '0;
      rise_q <= '0;
    end
    else
    begin
      hist_q <= sync_q[pulse_pkg::SYNC_STAGES-1];
      // high now, low last cycle
      rise_q <= sync_q[pulse_pkg::SYNC_STAGES-1] & ~hist_q;
    end
  end

  assign pin_level = sync_q[pulse_pkg::SYNC_STAGES-1];
  assign rise      = rise_q;

  // a strobe never lasts two cycles, so one edge counts once downstream
  a_rise_single: assert property (@(posedge GPIO) disable iff (!hps_fpga_reset_n)
    (rise_q & $past(rise_q)) == '0);

endmodule

`default_nettype wire

// ==== src/pulse_channel.sv ====
`default_nettype none
`timescale 1ns/1ps

module pulse_channel (
  input  wire                       GPIO,
  input  wire                       hps_fpga_reset_n,
  input  wire                       rise,
  input  wire                       run,
  output buffer_pkg::chan_status_t  status
);

  buffer_pkg::chan_status_t status_q;
  buffer_pkg::addr_t        addr_next;
  logic                     hit_mark;
  logic                     take;

  // ====================
  // next-state helpers
  // ====================

  // edges only count while the run level is up
  assign take = rise & run;

  always_comb
  begin
    // explicit wrap after the upper half
    if (status_q.addr == buffer_pkg::FULL_MARK)
    begin
      addr_next = '0;
    end
    else
    begin
      addr_next = status_q.addr + 1'b1;
    end
  end

  // new address closes a half
  assign hit_mark = (addr_next == buffer_pkg::HALF_MARK) ||
                    (addr_next == buffer_pkg::FULL_MARK);

  // ====================
  // state register
  // ====================

  always_ff @(posedge GPIO or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      status_q <= '0;
    end
    else if (take)
    begin
      status_q.count <= status_q.count + 1'b1;
      status_q.addr  <= addr_next;
      if (hit_mark)
      begin
        // one more half filled, host reads the other one
        status_q.bank      <= status_q.bank + 1'b1;
        status_q.half_flag <= ~status_q.half_flag;
      end
    end
  end

  assign status = status_q;

  // count moves only one cycle after a gated edge
  a_count_gated: assert property (@(posedge GPIO) disable iff (!hps_fpga_reset_n)
    $changed(status_q.count) |-> $past(rise && run));

  // flag toggles only on landing at a mark
  a_flag_at_mark: assert property (@(posedge GPIO) disable iff (!hps_fpga_reset_n)
    $changed(status_q.half_flag) |->
      $changed(status_q.addr) &&
      ((status_q.addr == buffer_pkg::HALF_MARK) ||
       (status_q.addr == buffer_pkg::FULL_MARK)));

endmodule

`default_nettype wire

// ==== src/count_readout.sv ====
`default_nettype none
`timescale 1ns/1ps

module count_readout (
  input  wire                            GPIO,
  input  wire                            hps_fpga_reset_n,
  input  wire pulse_pkg::chan_sel_t      sel,
  input  wire buffer_pkg::chan_status_t  chan_status [pulse_pkg::NUM_CHANNELS],
  output buffer_pkg::chan_status_t       status,
  output pulse_pkg::pulse_vec_t          half_flags
);

  buffer_pkg::chan_status_t status_q;
  pulse_pkg::pulse_vec_t    flags_d;
  pulse_pkg::pulse_vec_t    flags_q;

  // ====================
  // flag gather
  // ====================

  always_comb
  begin
    for (int i = 0; i < pulse_pkg::NUM_CHANNELS; i++)
    begin
      flags_d[i] = chan_status[i].half_flag;
    end
  end

  // ====================
  // output registers
  // ====================

  always_ff @(posedge GPIO or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      status_q <= '0;
      flags_q  <= '0;
    end
    else
    begin
      // selected word, one cycle behind sel
      status_q <= chan_status[sel];
      flags_q  <= flags_d;
    end
  end

  assign status     = status_q;
  assign half_flags = flags_q;

  // host must hold a defined select
  a_sel_known: assert property (@(posedge GPIO) disable iff (!hps_fpga_reset_n)
    !$isunknown(sel));

endmodule

`default_nettype wire

// ==== src/pulse_counter_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module pulse_counter_top (
  input  wire                        GPIO,
  input  wire                        hps_fpga_reset_n,
  input  wire pulse_pkg::pulse_vec_t pulse_in,
  input  wire                        run,
  input  wire pulse_pkg::chan_sel_t  sel,
  output pulse_pkg::pulse_vec_t      pin_level,
  output buffer_pkg::chan_status_t   status,
  output pulse_pkg::pulse_vec_t      half_flags
);

  // per-channel edge strobes
  wire pulse_pkg::pulse_vec_t    rise;
  // one status word per channel
  wire buffer_pkg::chan_status_t chan_status [pulse_pkg::NUM_CHANNELS];

  // ====================
  // input sync
  // ====================

  pulse_sync_bank u_sync (
    .GPIO             (GPIO),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .pulse_in         (pulse_in),
    .rise             (rise),
    .pin_level        (pin_level)
  );

  // ====================
  // channels
  // ====================

  for (genvar i = 0; i < pulse_pkg::NUM_CHANNELS; i++)
  begin : g_chan
    pulse_channel u_chan (
      .GPIO             (GPIO),
      .hps_fpga_reset_n (hps_fpga_reset_n),
      .rise             (rise[i]),
      .run              (run),
      .status           (chan_status[i])
    );
  end

  // ====================
  // host readout
  // ====================

  count_readout u_readout (
    .GPIO             (GPIO),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .sel              (sel),
    .chan_status      (chan_status),
    .status           (status),
    .half_flags       (half_flags)
  );

endmodule

`default_nettype wire

// ==== tb/tb_pulse_counter_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_pulse_counter_top;

  localparam int CLK_HALF_NS   = 20;
  localparam int RESET_CYCLES  = 4;
  localparam int SETTLE_CYCLES = 8;
  // longest test is the buffer-mark run of 32768 pulses at 4 cycles each
  localparam int MARK_TEST_CYCLES = 32768 * 4;
  // mark test plus headroom for the short tests
  localparam int TIMEOUT_CYCLES   = 200000;

  logic                     GPIO;
  logic                     hps_fpga_reset_n;
  pulse_pkg::pulse_vec_t    pulse_in;
  logic                     run;
  pulse_pkg::chan_sel_t     sel;
  pulse_pkg::pulse_vec_t    pin_level;
  buffer_pkg::chan_status_t status;
  pulse_pkg::pulse_vec_t    half_flags;

  // reference model with one entry per channel
  buffer_pkg::count_t ref_count [pulse_pkg::NUM_CHANNELS];
  buffer_pkg::addr_t  ref_addr  [pulse_pkg::NUM_CHANNELS];
  buffer_pkg::bank_t  ref_bank  [pulse_pkg::NUM_CHANNELS];
  logic               ref_flag  [pulse_pkg::NUM_CHANNELS];

  logic [31:0] rand_state;
  int          error_count;
  int          test_count;
  int          cycle_count;

  pulse_counter_top uut (
    .GPIO             (GPIO),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .pulse_in         (pulse_in),
    .run              (run),
    .sel              (sel),
    .pin_level        (pin_level),
    .status           (status),
    .half_flags       (half_flags)
  );

  // ====================
  // clock and helpers
  // ====================

  initial
  begin
    GPIO = 1'b0;
    forever #CLK_HALF_NS GPIO = ~GPIO;
  end

  // wait n edges and land 2 ns after the last one
  task automatic step(input int n);
    repeat (n)
    begin
      @(posedge GPIO);
      #2;
    end
  endtask

  task automatic apply_reset();
    hps_fpga_reset_n = 1'b0;
    step(RESET_CYCLES);
    hps_fpga_reset_n = 1'b1;
  endtask

  task automatic reset_model();
    for (int c = 0; c < pulse_pkg::NUM_CHANNELS; c++)
    begin
      ref_count[c] = '0;
      ref_addr[c]  = '0;
      ref_bank[c]  = '0;
      ref_flag[c]  = 1'b0;
    end
  endtask

  // one counted edge steps count and addr and may close a half
  task automatic model_edge(input int ch);
    ref_count[ch] = ref_count[ch] + 32'd1;
    if (ref_addr[ch] == 15'd32767)
      ref_addr[ch] = '0;
    else
      ref_addr[ch] = ref_addr[ch] + 15'd1;
    if (ref_addr[ch] == 15'd16383 || ref_addr[ch] == 15'd32767)
    begin
      ref_bank[ch] = ref_bank[ch] + 16'd1;
      ref_flag[ch] = ~ref_flag[ch];
    end
  endtask

  // n pulses of 2 cycles high then 2 low with run held steady
  task automatic pulse(input int ch, input int n);
    for (int k = 0; k < n; k++)
    begin
      pulse_in[ch] = 1'b1;
      step(2);
      pulse_in[ch] = 1'b0;
      step(2);
      if (run)
        model_edge(ch);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] got);
    $display("FAILED at %0d ns: %s expected %0h got %0h", $time, name, expected, got);
    error_count++;
  endtask

  // select a channel and let the readout settle before comparing
  task automatic check_channel(input int ch);
    sel = pulse_pkg::chan_sel_t'(ch);
    step(SETTLE_CYCLES);
    if (status.count !== ref_count[ch])
      report_mismatch("status.count", 64'(ref_count[ch]), 64'(status.count));
    if (status.addr !== ref_addr[ch])
      report_mismatch("status.addr", 64'(ref_addr[ch]), 64'(status.addr));
    if (status.bank !== ref_bank[ch])
      report_mismatch("status.bank", 64'(ref_bank[ch]), 64'(status.bank));
    if (status.half_flag !== ref_flag[ch])
      report_mismatch("status.half_flag", 64'(ref_flag[ch]), 64'(status.half_flag));
    if (half_flags[ch] !== ref_flag[ch])
      report_mismatch("half_flags", 64'(ref_flag[ch]), 64'(half_flags[ch]));
  endtask

  task automatic check_all();
    for (int c = 0; c < pulse_pkg::NUM_CHANNELS; c++)
      check_channel(c);
  endtask

  task automatic end_test(input string name, input int errors_at_start);
    test_count++;
    $display("test %s done, %0d errors", name, error_count - errors_at_start);
  endtask

  // ====================
  // directed tests
  // ====================

  task automatic test_reset_values();
    int start;
    start = error_count;
    for (int c = 0; c < pulse_pkg::NUM_CHANNELS; c++)
    begin
      sel = pulse_pkg::chan_sel_t'(c);
      step(SETTLE_CYCLES);
      if (status !== '0)
        report_mismatch("status", 64'd0, 64'(status));
    end
    if (half_flags !== '0)
      report_mismatch("half_flags", 64'd0, 64'(half_flags));
    if (pin_level !== '0)
      report_mismatch("pin_level", 64'd0, 64'(pin_level));
    end_test("reset_values", start);
  endtask

  task automatic test_independent_counting();
    int start;
    int n;
    start = error_count;
    run = 1'b1;
    step(2);
    for (int c = 0; c < pulse_pkg::NUM_CHANNELS; c++)
    begin
      // 1 to 50 pulses per channel
      n = 1 + int'((lcg_next() >> 8) % 32'd50);
      pulse(c, n);
    end
    check_all();
    end_test("independent_counting", start);
  endtask

  task automatic test_run_gating();
    int start;
    start = error_count;
    run = 1'b0;
    step(SETTLE_CYCLES);
    // edges ignored so the model stays put
    for (int c = 0; c < pulse_pkg::NUM_CHANNELS; c++)
      pulse(c, 3);
    check_all();
    run = 1'b1;
    step(SETTLE_CYCLES);
    for (int c = 0; c < pulse_pkg::NUM_CHANNELS; c++)
      pulse(c, 2 + c);
    check_all();
    end_test("run_gating", start);
  endtask

  task automatic test_buffer_marks();
    int start;
    start = error_count;
    apply_reset();
    reset_model();
    run = 1'b1;
    step(2);
    // lower half fills
    pulse(2, 16383);
    check_channel(2);
    // upper half fills
    pulse(2, 16384);
    check_channel(2);
    // wrap back to address zero
    pulse(2, 1);
    check_channel(2);
    end_test("buffer_marks", start);
  endtask

  task automatic test_pin_mirror();
    int start;
    pulse_pkg::pulse_vec_t patterns [4];
    start = error_count;
    patterns[0] = 4'b0101;
    patterns[1] = 4'b1010;
    patterns[2] = 4'b1111;
    patterns[3] = 4'b0000;
    run = 1'b0;
    for (int p = 0; p < 4; p++)
    begin
      pulse_in = patterns[p];
      step(SETTLE_CYCLES);
      if (pin_level !== patterns[p])
        report_mismatch("pin_level", 64'(patterns[p]), 64'(pin_level));
    end
    end_test("pin_mirror", start);
  endtask

  // ====================
  // main sequence
  // ====================

  initial
  begin
    hps_fpga_reset_n = 1'b0;
    pulse_in         = '0;
    run              = 1'b0;
    sel              = '0;
    rand_state       = 32'h6c7a_34d9;
    error_count      = 0;
    test_count       = 0;
    reset_model();
    apply_reset();

    test_reset_values();
    test_independent_counting();
    test_run_gating();
    test_buffer_marks();
    test_pin_mirror();

    $display("tests run: %0d, errors: %0d", test_count, error_count);
    if (error_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // cycle budget that ends a hung run
  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge GPIO);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles (mark test needs %0d)",
             TIMEOUT_CYCLES, MARK_TEST_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
src/pulse_pkg.sv
src/buffer_pkg.sv
src/pulse_sync_bank.sv
src/pulse_channel.sv
src/count_readout.sv
src/pulse_counter_top.sv
tb/tb_pulse_counter_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pulse counter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
TOP=tb_pulse_counter_top

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module "$TOP" -o sim_"$TOP"

./obj_dir/sim_"$TOP" 2>&1 | tee "$LOG"

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
echo "simulation passed"
